//--- Makefile
SIM       := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_tcdm_subsystem
FILELIST  := vlog.f
BUILD_DIR := obj_dir
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- common/tcdm_pkg.sv
// tcdm package: sizes, address map helpers and request, response and control structs

package tcdm_pkg;

  // cluster shape
  localparam int unsigned N_CORES    = 4;
  localparam int unsigned N_BANKS    = 8;

  // data path
  localparam int unsigned DW         = 32;
  localparam int unsigned BE_W       = DW / 8;   // one enable per byte

  // core side address, byte addressed
  localparam int unsigned AW         = 32;
  localparam int unsigned BYTE_OFF_W = 2;        // byte bits, ignored
  localparam int unsigned BANK_SEL_W = 3;        // word interleaving over banks

  // bank side address, word addressed
  localparam int unsigned BANK_WORDS = 64;
  localparam int unsigned BANK_AW    = 6;

  localparam int unsigned CORE_ID_W  = 2;

  typedef logic [CORE_ID_W-1:0]  core_id_t;
  typedef logic [BANK_SEL_W-1:0] bank_id_t;

  // one core request, wen high means read
  typedef struct packed {
    logic [AW-1:0]   add;
    logic            wen;
    logic [DW-1:0]   wdata;
    logic [BE_W-1:0] be;
  } core_req_t;

  // one bank request with the word address inside the bank
  typedef struct packed {
    logic [BANK_AW-1:0] add;
    logic               wen;
    logic [DW-1:0]      wdata;
    logic [BE_W-1:0]    be;
  } mem_req_t;

  // global interconnect control
  typedef struct packed {
    logic rr_en;   // 1: round robin, 0: fixed priority
  } ic_ctrl_t;

  // bits 4:2 pick the bank
  function automatic bank_id_t addr_bank(input logic [AW-1:0] add);
    return add[BYTE_OFF_W +: BANK_SEL_W];
  endfunction

  // bits 10:5 pick the word, upper bits alias
  function automatic logic [BANK_AW-1:0] addr_word(input logic [AW-1:0] add);
    return add[BYTE_OFF_W+BANK_SEL_W +: BANK_AW];
  endfunction

endpackage

//--- log_interconnect/bank_arbiter.sv
// bank arbiter: grants one requesting core per cycle, round robin or fixed priority

`timescale 1ns/1ps

module bank_arbiter
  import tcdm_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  ic_ctrl_t           ctrl_i,
  input  logic [N_CORES-1:0] req_i,    // requests already decoded for this bank
  output logic [N_CORES-1:0] gnt_o,
  output core_id_t           win_o,
  output logic               valid_o
);

  // first core searched in round robin mode
  core_id_t rr_ptr_q;

  // priority search, starting at the pointer or at core 0
  always_comb begin
    core_id_t idx;
    idx     = '0;
    win_o   = '0;
    valid_o = 1'b0;
    for (int unsigned k = 0; k < N_CORES; k++) begin
      if (ctrl_i.rr_en) begin
        idx = core_id_t'(rr_ptr_q + k);   // wraps around
      end else begin
        idx = core_id_t'(k);
      end
      if (!valid_o && req_i[idx]) begin
        valid_o = 1'b1;
        win_o   = idx;
      end
    end
  end

  // one-hot grant toward the cores
  always_comb begin
    gnt_o = '0;
    for (int unsigned i = 0; i < N_CORES; i++) begin
      gnt_o[i] = valid_o && (win_o == core_id_t'(i));
    end
  end

  // pointer moves past the winner, only on a grant
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr_q <= '0;
    end else if (valid_o) begin
      rr_ptr_q <= core_id_t'(win_o + 1'b1);
    end
  end

endmodule

//--- log_interconnect/log_interconnect.sv
// logarithmic interconnect: decodes core addresses, arbitrates per bank and routes responses

`timescale 1ns/1ps

module log_interconnect
  import tcdm_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  ic_ctrl_t                       ctrl_i,
  // core side
  input  logic      [N_CORES-1:0]        req_i,
  input  core_req_t [N_CORES-1:0]        core_req_i,
  output logic      [N_CORES-1:0]        gnt_o,
  output logic      [N_CORES-1:0]        r_valid_o,
  output logic      [N_CORES-1:0][DW-1:0] r_rdata_o,
  // bank side
  output logic      [N_BANKS-1:0]        bank_req_o,
  output mem_req_t  [N_BANKS-1:0]        bank_mreq_o,
  input  logic      [N_BANKS-1:0][DW-1:0] bank_rdata_i
);

  bank_id_t [N_CORES-1:0]              core_bank;      // target bank of each core
  logic     [N_BANKS-1:0][N_CORES-1:0] bank_core_req;  // request mask seen by each bank
  logic     [N_BANKS-1:0][N_CORES-1:0] bank_gnt;
  core_id_t [N_BANKS-1:0]              bank_win;
  logic     [N_BANKS-1:0]              bank_valid;

  // address decode and per bank request masks
  always_comb begin
    for (int unsigned c = 0; c < N_CORES; c++) begin
      core_bank[c] = addr_bank(core_req_i[c].add);
    end
    for (int unsigned b = 0; b < N_BANKS; b++) begin
      for (int unsigned c = 0; c < N_CORES; c++) begin
        bank_core_req[b][c] = req_i[c] && (core_bank[c] == bank_id_t'(b));
      end
    end
  end

  for (genvar b = 0; b < N_BANKS; b++) begin : gen_bank
    bank_arbiter u_bank_arbiter (
      .clk_i   ( clk_i            ),
      .rst_n_i ( rst_n_i          ),
      .ctrl_i  ( ctrl_i           ),
      .req_i   ( bank_core_req[b] ),
      .gnt_o   ( bank_gnt[b]      ),
      .win_o   ( bank_win[b]      ),
      .valid_o ( bank_valid[b]    )
    );

    // winner's request toward the bank, byte address turned into word address
    assign bank_req_o[b]        = bank_valid[b];
    assign bank_mreq_o[b].add   = addr_word(core_req_i[bank_win[b]].add);
    assign bank_mreq_o[b].wen   = core_req_i[bank_win[b]].wen;
    assign bank_mreq_o[b].wdata = core_req_i[bank_win[b]].wdata;
    assign bank_mreq_o[b].be    = core_req_i[bank_win[b]].be;
  end

  // a core is granted by at most one bank
  always_comb begin
    gnt_o = '0;
    for (int unsigned b = 0; b < N_BANKS; b++) begin
      gnt_o = gnt_o | bank_gnt[b];
    end
  end

  resp_router u_resp_router (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .bank_valid_i ( bank_valid   ),
    .bank_win_i   ( bank_win     ),
    .bank_rdata_i ( bank_rdata_i ),
    .r_valid_o    ( r_valid_o    ),
    .r_rdata_o    ( r_rdata_o    )
  );

endmodule

//--- log_interconnect/resp_router.sv
// response router: returns each bank's read data and r_valid to the core it served

`timescale 1ns/1ps

module resp_router
  import tcdm_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic     [N_BANKS-1:0]       bank_valid_i,
  input  core_id_t [N_BANKS-1:0]       bank_win_i,
  input  logic     [N_BANKS-1:0][DW-1:0] bank_rdata_i,
  output logic     [N_CORES-1:0]       r_valid_o,
  output logic     [N_CORES-1:0][DW-1:0] r_rdata_o
);

  // who each bank served last cycle
  typedef struct packed {
    logic     valid;
    core_id_t core;
  } route_t;

  route_t [N_BANKS-1:0] route_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      route_q <= '0;
    end else begin
      for (int unsigned b = 0; b < N_BANKS; b++) begin
        route_q[b].valid <= bank_valid_i[b];
        route_q[b].core  <= bank_win_i[b];
      end
    end
  end

  // at most one bank answers a given core, so plain steering is enough
  always_comb begin
    r_valid_o = '0;
    r_rdata_o = '0;
    for (int unsigned b = 0; b < N_BANKS; b++) begin
      if (route_q[b].valid) begin
        r_valid_o[route_q[b].core] = 1'b1;
        r_rdata_o[route_q[b].core] = bank_rdata_i[b];   // bank output is already registered
      end
    end
  end

endmodule

//--- src/tcdm_bank.sv
// tcdm bank: single port word memory with byte enables and one cycle read

`timescale 1ns/1ps

module tcdm_bank
  import tcdm_pkg::*;
(
  input  logic          clk_i,
  input  logic          req_i,
  input  mem_req_t      mreq_i,
  output logic [DW-1:0] rdata_o
);

  logic [DW-1:0] mem_q [BANK_WORDS];

  // byte lane write, only the enabled lanes change
  always_ff @(posedge clk_i) begin
    if (req_i && !mreq_i.wen) begin
      for (int unsigned i = 0; i < BE_W; i++) begin
        if (mreq_i.be[i]) begin
          mem_q[mreq_i.add][8*i +: 8] <= mreq_i.wdata[8*i +: 8];
        end
      end
    end
  end

  // read on every access, a write returns the old word
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= mem_q[mreq_i.add];
    end
  end

endmodule

//--- src/tcdm_subsystem.sv
// tcdm subsystem: four cores reach eight interleaved banks through the log interconnect

`timescale 1ns/1ps

module tcdm_subsystem
  import tcdm_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  ic_ctrl_t                       ctrl_i,
  input  logic      [N_CORES-1:0]        req_i,
  input  core_req_t [N_CORES-1:0]        core_req_i,
  output logic      [N_CORES-1:0]        gnt_o,
  output logic      [N_CORES-1:0]        r_valid_o,
  output logic      [N_CORES-1:0][DW-1:0] r_rdata_o
);

  logic     [N_BANKS-1:0]         bank_req;
  mem_req_t [N_BANKS-1:0]         bank_mreq;
  logic     [N_BANKS-1:0][DW-1:0] bank_rdata;

  log_interconnect u_log_interconnect (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .ctrl_i       ( ctrl_i     ),
    .req_i        ( req_i      ),
    .core_req_i   ( core_req_i ),
    .gnt_o        ( gnt_o      ),
    .r_valid_o    ( r_valid_o  ),
    .r_rdata_o    ( r_rdata_o  ),
    .bank_req_o   ( bank_req   ),
    .bank_mreq_o  ( bank_mreq  ),
    .bank_rdata_i ( bank_rdata )
  );

  // banks always accept, no bank side grant
  for (genvar b = 0; b < N_BANKS; b++) begin : gen_bank
    tcdm_bank u_tcdm_bank (
      .clk_i   ( clk_i         ),
      .req_i   ( bank_req[b]   ),
      .mreq_i  ( bank_mreq[b]  ),
      .rdata_o ( bank_rdata[b] )
    );
  end

endmodule

//--- testbench/tb_tcdm_subsystem.sv
// tcdm subsystem testbench that checks table driven core traffic against a reference model

`timescale 1ns/1ps

module tb_tcdm_subsystem
  import tcdm_pkg::*;
();

  logic                            clk;
  logic                            rst_n;
  ic_ctrl_t                        ctrl;
  logic      [N_CORES-1:0]         req;
  core_req_t [N_CORES-1:0]         core_req;
  logic      [N_CORES-1:0]         gnt;
  logic      [N_CORES-1:0]         r_valid;
  logic      [N_CORES-1:0][DW-1:0] r_rdata;

  // one table row where all masked cores request in the same cycle
  typedef struct packed {
    logic                         rr_en;
    logic [N_CORES-1:0]           mask;
    logic [N_CORES-1:0]           wen;     // high means read
    logic                         rnd;     // write data from xorshift
    logic [N_CORES-1:0][AW-1:0]   add;
    logic [N_CORES-1:0][BE_W-1:0] be;
  } row_t;

  // expected answer of one granted access
  typedef struct packed {
    logic          is_read;
    logic [DW-1:0] data;
  } resp_t;

  row_t                       rows [$];
  row_t                       cur;
  logic [N_CORES-1:0][DW-1:0] cur_wdata;
  logic [N_CORES-1:0]         pending;     // requests not yet granted
  logic [DW-1:0]              shadow [N_BANKS][BANK_WORDS];
  core_id_t                   rr_ptr [N_BANKS];
  resp_t                      resp_q [N_CORES][$];
  logic [31:0]                rng_state;
  logic                       timed_out;
  int unsigned                n_checks;
  int unsigned                win_errs;
  int unsigned                data_errs;
  int unsigned                strobe_errs;
  int unsigned                wait_errs;

  tcdm_subsystem u_tcdm_subsystem (
    .clk_i      ( clk      ),
    .rst_n_i    ( rst_n    ),
    .ctrl_i     ( ctrl     ),
    .req_i      ( req      ),
    .core_req_i ( core_req ),
    .gnt_o      ( gnt      ),
    .r_valid_o  ( r_valid  ),
    .r_rdata_o  ( r_rdata  )
  );

  always #10 clk = ~clk;   // 20 ns period

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // known write data tagged with row and core
  function automatic logic [DW-1:0] fixed_data(input int unsigned row, input int unsigned core);
    logic [DW-1:0] d;
    d       = 32'hd0c0_0000;
    d[15:8] = 8'(row);
    d[7:0]  = 8'(core);
    return d;
  endfunction

  // bits 4:2 give the bank and bits 10:5 the word while upper bits alias
  function automatic bank_id_t bank_of(input logic [AW-1:0] add);
    return add[4:2];
  endfunction

  function automatic logic [BANK_AW-1:0] word_of(input logic [AW-1:0] add);
    return add[10:5];
  endfunction

  task automatic expect_winner(input string name, input core_id_t exp, input core_id_t act);
    n_checks++;
    if (act !== exp) begin
      win_errs++;
      $display("error at %0t: %s expected core %0d, got core %0d", $time, name, exp, act);
    end
  endtask

  task automatic compare_data(input string name, input logic [DW-1:0] exp,
                              input logic [DW-1:0] act);
    n_checks++;
    if (act !== exp) begin
      data_errs++;
      $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_mask(input string name, input logic [N_CORES-1:0] exp,
                            input logic [N_CORES-1:0] act);
    n_checks++;
    if (act !== exp) begin
      strobe_errs++;
      $display("error at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic add_row(input logic rr, input logic [N_CORES-1:0] mask,
                         input logic [N_CORES-1:0] wen, input logic [N_CORES*BE_W-1:0] be,
                         input logic rnd, input logic [AW-1:0] a0, input logic [AW-1:0] a1,
                         input logic [AW-1:0] a2, input logic [AW-1:0] a3);
    row_t r;
    r.rr_en = rr;
    r.mask  = mask;
    r.wen   = wen;
    r.rnd   = rnd;
    r.add   = {a3, a2, a1, a0};
    r.be    = be;
    rows.push_back(r);
  endtask

  task automatic load_table();
    // rr, mask, wen, be {c3..c0}, rnd, address of core 0..3
    add_row(1'b0, 4'hf, 4'h0, 16'hffff, 1'b1, 32'h000, 32'h004, 32'h008, 32'h00c);
    add_row(1'b0, 4'hf, 4'h0, 16'hffff, 1'b1, 32'h010, 32'h014, 32'h018, 32'h01c);
    add_row(1'b0, 4'hf, 4'h0, 16'h85c3, 1'b0, 32'h000, 32'h004, 32'h008, 32'h00c);
    add_row(1'b0, 4'hf, 4'hf, 16'hffff, 1'b0, 32'h000, 32'h004, 32'h008, 32'h00c);
    // one bank under fixed priority
    add_row(1'b0, 4'hf, 4'h0, 16'hffff, 1'b1, 32'h008, 32'h028, 32'h048, 32'h068);
    add_row(1'b0, 4'hf, 4'hf, 16'hffff, 1'b0, 32'h068, 32'h048, 32'h028, 32'h008);
    // one bank with round robin rotation
    add_row(1'b1, 4'hf, 4'hf, 16'hffff, 1'b0, 32'h068, 32'h048, 32'h028, 32'h008);
    add_row(1'b1, 4'h6, 4'hf, 16'hffff, 1'b0, 32'h008, 32'h028, 32'h048, 32'h068);
    add_row(1'b1, 4'hf, 4'hf, 16'hffff, 1'b0, 32'h008, 32'h028, 32'h048, 32'h068);
    add_row(1'b1, 4'hb, 4'h0, 16'hffff, 1'b1, 32'h008, 32'h028, 32'h048, 32'h068);
    add_row(1'b1, 4'hf, 4'hf, 16'hffff, 1'b0, 32'h068, 32'h048, 32'h028, 32'h008);
    add_row(1'b1, 4'hf, 4'hf, 16'hffff, 1'b0, 32'h014, 32'h014, 32'h018, 32'h018);
    // interleaving and aliasing of the upper bits
    add_row(1'b0, 4'hf, 4'h0, 16'hffff, 1'b1, 32'h100, 32'h104, 32'h108, 32'h10c);
    add_row(1'b0, 4'hf, 4'h0, 16'hffff, 1'b1, 32'h110, 32'h114, 32'h118, 32'h11c);
    add_row(1'b0, 4'hf, 4'hf, 16'hffff, 1'b0, 32'h8000_0100, 32'h4000_0104,
            32'h0001_0108, 32'hffff_f90c);
    add_row(1'b1, 4'hf, 4'hf, 16'hffff, 1'b0, 32'h0000_0910, 32'h1234_5914,
            32'hdead_b918, 32'h0000_f91c);
    add_row(1'b0, 4'h1, 4'h0, 16'h0006, 1'b1, 32'h7000_0100, 32'h0, 32'h0, 32'h0);
    add_row(1'b0, 4'h3, 4'hf, 16'hffff, 1'b0, 32'h100, 32'h2000_0104, 32'h0, 32'h0);
  endtask

  // one clock of driving, checking last cycle's answers and predicting grants
  task automatic step_cycle(input int unsigned wait_cyc);
    logic [N_CORES-1:0] exp_valid;
    logic [N_CORES-1:0] exp_gnt;
    logic [N_BANKS-1:0] has_win;
    core_id_t           win [N_BANKS];
    core_id_t           idx;
    core_id_t           act;
    resp_t              rsp;
    logic [BANK_AW-1:0] w;
    @(negedge clk);
    ctrl.rr_en = cur.rr_en;
    req        = pending;
    for (int unsigned c = 0; c < N_CORES; c++) begin
      core_req[c].add   = cur.add[c];
      core_req[c].wen   = cur.wen[c];
      core_req[c].wdata = cur_wdata[c];
      core_req[c].be    = cur.be[c];
    end
    #5;
    for (int unsigned c = 0; c < N_CORES; c++) begin
      exp_valid[c] = resp_q[c].size() != 0;
    end
    check_mask("r_valid_o", exp_valid, r_valid);
    for (int unsigned c = 0; c < N_CORES; c++) begin
      if (resp_q[c].size() != 0) begin
        rsp = resp_q[c].pop_front();
        if (rsp.is_read && r_valid[c]) begin
          compare_data($sformatf("r_rdata_o[%0d]", c), rsp.data, r_rdata[c]);
        end
      end
    end
    exp_gnt = '0;
    has_win = '0;
    for (int unsigned b = 0; b < N_BANKS; b++) begin
      win[b] = '0;
      for (int unsigned k = 0; k < N_CORES; k++) begin
        idx = cur.rr_en ? core_id_t'(int'(rr_ptr[b]) + k) : core_id_t'(k);
        if (!has_win[b] && pending[idx] && bank_of(cur.add[idx]) == bank_id_t'(b)) begin
          has_win[b] = 1'b1;
          win[b]     = idx;
        end
      end
      if (has_win[b]) begin
        exp_gnt[win[b]] = 1'b1;
      end
    end
    check_mask("gnt_o", exp_gnt, gnt);
    for (int unsigned b = 0; b < N_BANKS; b++) begin
      if (has_win[b]) begin
        act = 'x;
        for (int unsigned c = 0; c < N_CORES; c++) begin
          if (pending[c] && gnt[c] && bank_of(cur.add[c]) == bank_id_t'(b)) begin
            act = core_id_t'(c);
          end
        end
        expect_winner($sformatf("winner of bank %0d", b), win[b], act);
        // model side of the access where a write also answers with the old word
        w           = word_of(cur.add[win[b]]);
        rsp.is_read = cur.wen[win[b]];
        rsp.data    = shadow[b][w];
        resp_q[win[b]].push_back(rsp);
        if (!cur.wen[win[b]]) begin
          for (int unsigned i = 0; i < BE_W; i++) begin
            if (cur.be[win[b]][i]) begin
              shadow[b][w][8*i +: 8] = cur_wdata[win[b]][8*i +: 8];
            end
          end
        end
        rr_ptr[b] = core_id_t'(int'(win[b]) + 1);
      end
    end
    // a request drops only once the DUT grants it
    for (int unsigned c = 0; c < N_CORES; c++) begin
      if (pending[c] && gnt[c]) begin
        pending[c] = 1'b0;
        if (wait_cyc > N_CORES - 1) begin
          wait_errs++;
          $display("core %0d waited %0d cycles for a grant, longer than allowed",
                   c, wait_cyc);
        end
      end
    end
  endtask

  initial begin
    int unsigned cyc;
    clk         = 1'b0;
    rst_n       = 1'b0;
    ctrl        = '0;
    req         = '0;
    core_req    = '0;
    cur         = '0;
    cur_wdata   = '0;
    pending     = '0;
    rng_state   = 32'h4ea9_b8f3;
    timed_out   = 1'b0;
    n_checks    = 0;
    win_errs    = 0;
    data_errs   = 0;
    strobe_errs = 0;
    wait_errs   = 0;
    for (int unsigned b = 0; b < N_BANKS; b++) begin
      rr_ptr[b] = '0;
    end
    load_table();

    // 4 cycles of reset with no requests
    for (int unsigned i = 0; i < 4; i++) begin
      @(negedge clk);
      check_mask("gnt_o in reset", '0, gnt);
      check_mask("r_valid_o in reset", '0, r_valid);
    end
    rst_n = 1'b1;
    step_cycle(0);   // idle cycle right after reset

    for (int unsigned i = 0; i < rows.size(); i++) begin
      cur = rows[i];
      for (int unsigned c = 0; c < N_CORES; c++) begin
        cur_wdata[c] = cur.rnd ? next_rand() : fixed_data(i, c);
      end
      pending = cur.mask;
      cyc     = 0;
      while (pending != '0 && cyc < 4 * N_CORES) begin
        step_cycle(cyc);
        cyc++;
      end
      if (pending != '0) begin
        $display("timeout in row %0d: requests %b never granted", i, pending);
        timed_out = 1'b1;
        break;
      end
    end
    if (!timed_out) begin
      pending = '0;
      step_cycle(0);   // answers of the last grants
    end

    $display("checks %0d, winner errors %0d, data errors %0d, strobe errors %0d, wait errors %0d",
             n_checks, win_errs, data_errs, strobe_errs, wait_errs);
    if (!timed_out && win_errs + data_errs + strobe_errs + wait_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- testbench/tcdm_subsystem_asserts.sv
// tcdm subsystem assertions: grants only on request, one response strobe per grant

`timescale 1ns/1ps

module tcdm_subsystem_asserts
  import tcdm_pkg::*;
(
  input logic               clk_i,
  input logic               rst_n_i,
  input logic [N_CORES-1:0] req_i,
  input logic [N_CORES-1:0] gnt_o,
  input logic [N_CORES-1:0] r_valid_o
);

  // grant needs a request in the same cycle
  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (gnt_o & ~req_i) == '0)
    else $error("grant without request, req %b gnt %b", req_i, gnt_o);

  for (genvar c = 0; c < N_CORES; c++) begin : gen_core
    resp_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      gnt_o[c] |=> r_valid_o[c])
      else $error("core %0d granted but no r_valid in the next cycle", c);

    // no strobe without a grant one cycle earlier
    resp_needs_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      r_valid_o[c] |-> $past(gnt_o[c]))
      else $error("core %0d got r_valid without a grant", c);
  end

  quiet_after_reset: assert property (@(posedge clk_i) $rose(rst_n_i) |-> r_valid_o == '0)
    else $error("r_valid high in the first cycle after reset");

endmodule

bind tcdm_subsystem tcdm_subsystem_asserts u_tcdm_subsystem_asserts (
  .clk_i     ( clk_i     ),
  .rst_n_i   ( rst_n_i   ),
  .req_i     ( req_i     ),
  .gnt_o     ( gnt_o     ),
  .r_valid_o ( r_valid_o )
);

//--- vlog.f
common/tcdm_pkg.sv
log_interconnect/bank_arbiter.sv
log_interconnect/resp_router.sv
log_interconnect/log_interconnect.sv
src/tcdm_bank.sv
src/tcdm_subsystem.sv
testbench/tcdm_subsystem_asserts.sv
testbench/tb_tcdm_subsystem.sv
